/* verilog/rename_pkg.sv */
//////////////////////////////
// Sizes, index types and opcodes shared by the
// register-renaming pipeline and its testbench.
// Files refer to these by scoped name.
//////////////////////////////
package rename_pkg;

  // Register counts
  localparam int ARCH_REGS = 8;
  localparam int PHYS_REGS = 16;
  localparam int FREE_REGS = PHYS_REGS - ARCH_REGS;  // Unmapped after reset

  // Widths
  localparam int DATA_W = 16;
  localparam int INST_W = 16;
  localparam int IMM_W  = 9;   // LDI immediate in bits 8:0

  // Credit flow control at the two external boundaries
  localparam int IN_DEPTH    = 4;  // Input FIFO entries = sender credits
  localparam int OUT_CREDITS = 2;  // Consumer slots after reset

  typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
  typedef logic [$clog2(PHYS_REGS)-1:0] phys_idx_t;
  typedef logic [DATA_W-1:0]            data_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Instruction layout
  //   15:12 opcode, 11:9 rd, 8:6 rs1, 5:3 rs2
  //   8:0 immediate for LDI
  // Codes not listed are illegal
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,  // rd = rs1 + rs2
    OP_SUB = 4'h1,  // rd = rs1 - rs2
    OP_AND = 4'h2,  // rd = rs1 & rs2
    OP_XOR = 4'h3,  // rd = rs1 ^ rs2
    OP_LDI = 4'h4   // rd = zero extended imm
  } opcode_e;

endpackage

/* verilog/decode_stage.sv */
//////////////////////////////
// Decode stage. Buffers incoming instructions in a
// small FIFO, returns one input credit per entry
// popped, splits the fields and drops illegal
// opcodes while raising a sticky error flag.
//////////////////////////////
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          in_valid,
  input  logic [rename_pkg::INST_W-1:0] in_inst,
  input  logic                          ren_stall,
  output logic                          in_credit,
  output logic                          dec_valid,
  output rename_pkg::opcode_e           dec_op,
  output rename_pkg::arch_idx_t         dec_rd,
  output rename_pkg::arch_idx_t         dec_rs1,
  output rename_pkg::arch_idx_t         dec_rs2,
  output logic [rename_pkg::IMM_W-1:0]  dec_imm,
  output logic                          illegal
);

  logic [rename_pkg::INST_W-1:0]               fifo_mem [rename_pkg::IN_DEPTH];
  logic [$clog2(rename_pkg::IN_DEPTH)-1:0]     wr_ptr;
  logic [$clog2(rename_pkg::IN_DEPTH)-1:0]     rd_ptr;
  logic [$clog2(rename_pkg::IN_DEPTH+1)-1:0]   count;
  logic [rename_pkg::INST_W-1:0]               head_inst;
  rename_pkg::opcode_e                         head_op;
  logic                                        head_legal;
  logic                                        pop;

  assign head_inst = fifo_mem[rd_ptr];
  assign head_op   = rename_pkg::opcode_e'(head_inst[15:12]);
  // Pop when the output register is empty or moving on
  assign pop       = (count != '0) && (!dec_valid || !ren_stall);

  always_comb begin
    case (head_op)
      rename_pkg::OP_ADD, rename_pkg::OP_SUB, rename_pkg::OP_AND,
      rename_pkg::OP_XOR, rename_pkg::OP_LDI: head_legal = 1'b1;
      default:                                head_legal = 1'b0;
    endcase
  end

  //////////////////////////////
  // Input FIFO
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (in_valid) begin  // Sender only sends while holding a credit
      fifo_mem[wr_ptr] <= in_inst;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      in_credit <= pop;  // Also for dropped entries
    end
  end

  //////////////////////////////
  // Decode register
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      if (!dec_valid || !ren_stall) begin
        dec_valid <= pop && head_legal;  // Illegal entry leaves a bubble
      end
      if (pop && !head_legal) begin
        illegal <= 1'b1;  // Sticky until reset
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      dec_op  <= head_op;
      dec_rd  <= head_inst[11:9];
      dec_rs1 <= head_inst[8:6];
      dec_rs2 <= head_inst[5:3];
      dec_imm <= head_inst[8:0];
    end
  end

endmodule

/* verilog/rename_stage.sv */
//////////////////////////////
// Rename stage. Maps architectural registers to
// physical ones through a map table and a circular
// free list. Each destination gets a fresh register
// and the one it replaces travels on for release at
// commit.
//////////////////////////////
`timescale 1ns/1ps

module rename_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          dec_valid,
  input  rename_pkg::opcode_e           dec_op,
  input  rename_pkg::arch_idx_t         dec_rd,
  input  rename_pkg::arch_idx_t         dec_rs1,
  input  rename_pkg::arch_idx_t         dec_rs2,
  input  logic [rename_pkg::IMM_W-1:0]  dec_imm,
  input  logic                          exe_stall,
  input  logic                          free_valid,
  input  rename_pkg::phys_idx_t         free_prd,
  output logic                          ren_stall,
  output logic                          ren_valid,
  output rename_pkg::opcode_e           ren_op,
  output rename_pkg::arch_idx_t         ren_rd,
  output rename_pkg::phys_idx_t         ren_prd,
  output rename_pkg::phys_idx_t         ren_old_prd,
  output rename_pkg::phys_idx_t         ren_prs1,
  output rename_pkg::phys_idx_t         ren_prs2,
  output logic [rename_pkg::IMM_W-1:0]  ren_imm
);

  rename_pkg::phys_idx_t                        map_table [rename_pkg::ARCH_REGS];
  rename_pkg::phys_idx_t                        free_list [rename_pkg::FREE_REGS];
  logic [$clog2(rename_pkg::FREE_REGS)-1:0]     free_head;
  logic [$clog2(rename_pkg::FREE_REGS)-1:0]     free_tail;
  logic [$clog2(rename_pkg::FREE_REGS+1)-1:0]   free_count;
  logic                                         move_in;

  // Blocked downstream, or nothing left to allocate
  assign ren_stall = (ren_valid && exe_stall) || (free_count == '0);
  assign move_in   = dec_valid && !ren_stall;

  //////////////////////////////
  // Map table and free list
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
        map_table[r] <= rename_pkg::phys_idx_t'(r);  // Identity mapping
      end
      for (int f = 0; f < rename_pkg::FREE_REGS; f++) begin
        free_list[f] <= rename_pkg::phys_idx_t'(rename_pkg::ARCH_REGS + f);
      end
      free_head  <= '0;
      free_tail  <= '0;
      free_count <= rename_pkg::FREE_REGS[$clog2(rename_pkg::FREE_REGS+1)-1:0];
    end else begin
      if (move_in) begin
        map_table[dec_rd] <= free_list[free_head];
        free_head         <= free_head + 1'b1;
      end
      // Released at commit and visible to rename next cycle
      if (free_valid) begin
        free_list[free_tail] <= free_prd;
        free_tail            <= free_tail + 1'b1;
      end
      case ({free_valid, move_in})
        2'b10:   free_count <= free_count + 1'b1;
        2'b01:   free_count <= free_count - 1'b1;
        default: free_count <= free_count;
      endcase
    end
  end

  //////////////////////////////
  // Rename register
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      ren_valid <= 1'b0;
    end else if (!ren_valid || !exe_stall) begin
      ren_valid <= move_in;
    end
  end

  // Sources read the table before this instruction's own update
  always_ff @(posedge clock) begin
    if (move_in) begin
      ren_op      <= dec_op;
      ren_rd      <= dec_rd;
      ren_imm     <= dec_imm;
      ren_prd     <= free_list[free_head];
      ren_old_prd <= map_table[dec_rd];   // Freed when this one commits
      ren_prs1    <= map_table[dec_rs1];
      ren_prs2    <= map_table[dec_rs2];
    end
  end

endmodule

/* verilog/execute_stage.sv */
//////////////////////////////
// Execute stage. Reads the physical register file,
// runs the single ALU and writes the result back at
// the same edge that registers it for commit.
//////////////////////////////
`timescale 1ns/1ps

module execute_stage (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          ren_valid,
  input  rename_pkg::opcode_e           ren_op,
  input  rename_pkg::arch_idx_t         ren_rd,
  input  rename_pkg::phys_idx_t         ren_prd,
  input  rename_pkg::phys_idx_t         ren_old_prd,
  input  rename_pkg::phys_idx_t         ren_prs1,
  input  rename_pkg::phys_idx_t         ren_prs2,
  input  logic [rename_pkg::IMM_W-1:0]  ren_imm,
  input  logic                          com_stall,
  output logic                          exe_stall,
  output logic                          exe_valid,
  output rename_pkg::arch_idx_t         exe_rd,
  output rename_pkg::phys_idx_t         exe_old_prd,
  output rename_pkg::data_t             exe_data
);

  rename_pkg::data_t regfile [rename_pkg::PHYS_REGS];
  rename_pkg::data_t src1;
  rename_pkg::data_t src2;
  rename_pkg::data_t result;
  logic              move_in;

  assign exe_stall = exe_valid && com_stall;
  assign move_in   = ren_valid && !exe_stall;

  // Combinational read lets a dependent one cycle behind see the write
  assign src1 = regfile[ren_prs1];
  assign src2 = regfile[ren_prs2];

  always_comb begin
    case (ren_op)
      rename_pkg::OP_ADD: result = src1 + src2;
      rename_pkg::OP_SUB: result = src1 - src2;
      rename_pkg::OP_AND: result = src1 & src2;
      rename_pkg::OP_XOR: result = src1 ^ src2;
      rename_pkg::OP_LDI: result = {{(rename_pkg::DATA_W-rename_pkg::IMM_W){1'b0}}, ren_imm};
      default:            result = '0;  // Filtered out at decode
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int p = 0; p < rename_pkg::PHYS_REGS; p++) begin
        regfile[p] <= '0;
      end
      exe_valid <= 1'b0;
    end else begin
      if (move_in) begin
        regfile[ren_prd] <= result;
      end
      if (!exe_valid || !com_stall) begin
        exe_valid <= move_in;
      end
    end
  end

  // Result register toward commit
  always_ff @(posedge clock) begin
    if (move_in) begin
      exe_rd      <= ren_rd;
      exe_old_prd <= ren_old_prd;
      exe_data    <= result;
    end
  end

endmodule

/* verilog/commit_stage.sv */
//////////////////////////////
// Commit stage. Holds one result and emits it in
// program order when the consumer has a free slot.
// The replaced physical register goes back to the
// free list in the same cycle.
//////////////////////////////
`timescale 1ns/1ps

module commit_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   exe_valid,
  input  rename_pkg::arch_idx_t  exe_rd,
  input  rename_pkg::phys_idx_t  exe_old_prd,
  input  rename_pkg::data_t      exe_data,
  input  logic                   commit_credit,
  output logic                   com_stall,
  output logic                   commit_valid,
  output rename_pkg::arch_idx_t  commit_reg,
  output rename_pkg::data_t      commit_data,
  output logic                   free_valid,
  output rename_pkg::phys_idx_t  free_prd
);

  logic                                          held_valid;
  logic [$clog2(rename_pkg::OUT_CREDITS+1)-1:0]  credits;
  logic                                          emit;
  logic                                          move_in;

  assign emit      = held_valid && (credits != '0);
  assign com_stall = held_valid && !emit;  // Item held while no credit is left
  assign move_in   = exe_valid && !com_stall;

  assign commit_valid = emit;
  assign free_valid   = emit;

  //////////////////////////////
  // Consumer credits
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      credits <= rename_pkg::OUT_CREDITS[$clog2(rename_pkg::OUT_CREDITS+1)-1:0];
    end else begin
      case ({emit, commit_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;   // None or both
      endcase
    end
  end

  // Commit register
  always_ff @(posedge clock) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (!held_valid || emit) begin
      held_valid <= move_in;
    end
  end

  always_ff @(posedge clock) begin
    if (move_in) begin
      commit_reg  <= exe_rd;
      commit_data <= exe_data;
      free_prd    <= exe_old_prd;
    end
  end

endmodule

/* verilog/rename_pipeline.sv */
//////////////////////////////
// Top level of the renaming pipeline. Chains decode,
// rename, execute and commit; credits are used at the
// input and output, valid and stall in between.
//////////////////////////////
`timescale 1ns/1ps

module rename_pipeline (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          in_valid,
  input  logic [rename_pkg::INST_W-1:0] in_inst,
  output logic                          in_credit,
  input  logic                          commit_credit,
  output logic                          commit_valid,
  output rename_pkg::arch_idx_t         commit_reg,
  output rename_pkg::data_t             commit_data,
  output logic                          illegal
);

  // Decode to rename
  logic                          dec_valid;
  rename_pkg::opcode_e           dec_op;
  rename_pkg::arch_idx_t         dec_rd;
  rename_pkg::arch_idx_t         dec_rs1;
  rename_pkg::arch_idx_t         dec_rs2;
  logic [rename_pkg::IMM_W-1:0]  dec_imm;
  logic                          ren_stall;

  // Rename to execute
  logic                          ren_valid;
  rename_pkg::opcode_e           ren_op;
  rename_pkg::arch_idx_t         ren_rd;
  rename_pkg::phys_idx_t         ren_prd;
  rename_pkg::phys_idx_t         ren_old_prd;
  rename_pkg::phys_idx_t         ren_prs1;
  rename_pkg::phys_idx_t         ren_prs2;
  logic [rename_pkg::IMM_W-1:0]  ren_imm;
  logic                          exe_stall;

  // Execute to commit, and the release path
  logic                          exe_valid;
  rename_pkg::arch_idx_t         exe_rd;
  rename_pkg::phys_idx_t         exe_old_prd;
  rename_pkg::data_t             exe_data;
  logic                          com_stall;
  logic                          free_valid;
  rename_pkg::phys_idx_t         free_prd;

  decode_stage  decode_0  (.*);
  rename_stage  rename_0  (.*);
  execute_stage execute_0 (.*);
  commit_stage  commit_0  (.*);

endmodule

/* sim/rename_pipeline_asserts.sv */
//////////////////////////////
// Concurrent checks on the external credit
// protocols, the sticky error flag and the reset
// state. Bound into the pipeline top level.
//////////////////////////////
`timescale 1ns/1ps

module rename_pipeline_asserts (
  input logic clock,
  input logic reset,
  input logic in_valid,
  input logic in_credit,
  input logic commit_valid,
  input logic commit_credit,
  input logic illegal
);

  int out_credits;     // Consumer slots as seen from outside
  int accepted;
  int returned;
  int fail_count = 0;  // Read by the testbench

  always_ff @(posedge clock) begin
    if (reset) begin
      out_credits <= rename_pkg::OUT_CREDITS;
      accepted    <= 0;
      returned    <= 0;
    end else begin
      out_credits <= out_credits - int'(commit_valid) + int'(commit_credit);
      accepted    <= accepted + int'(in_valid);
      returned    <= returned + int'(in_credit);
    end
  end

  commit_needs_credit: assert property (@(posedge clock) disable iff (reset)
    commit_valid |-> out_credits > 0)
    else begin
      $error("commit_valid raised with no consumer credit outstanding");
      fail_count++;
    end

  credit_after_accept: assert property (@(posedge clock) disable iff (reset)
    in_credit |-> returned < accepted)
    else begin
      $error("in_credit returned more credits than instructions accepted");
      fail_count++;
    end

  illegal_sticky: assert property (@(posedge clock) disable iff (reset)
    illegal |=> illegal)
    else begin
      $error("illegal flag dropped without a reset");
      fail_count++;
    end

  // Checked from the first edge after reset is seen
  quiet_in_reset: assert property (@(posedge clock)
    reset |=> !in_credit && !commit_valid && !illegal)
    else begin
      $error("in_credit, commit_valid or illegal high during or just after reset");
      fail_count++;
    end

endmodule

bind rename_pipeline rename_pipeline_asserts asserts_0 (.*);

/* sim/rename_pipeline_tb.sv */
//////////////////////////////
// Testbench for the renaming pipeline. Programs come
// from an LFSR, an architectural register model
// predicts every commit, and both credit boundaries
// are exercised including back-pressure.
//////////////////////////////
`timescale 1ns/1ps

module rename_pipeline_tb;

  localparam int WAIT_LIMIT = 300;  // Cycles per wait loop

  logic                          clock = 1'b0;
  logic                          reset;
  logic                          in_valid;
  logic [rename_pkg::INST_W-1:0] in_inst;
  logic                          in_credit;
  logic                          commit_credit;
  logic                          commit_valid;
  rename_pkg::arch_idx_t         commit_reg;
  rename_pkg::data_t             commit_data;
  logic                          illegal;

  logic [31:0]           lfsr = 32'h851d0e97;
  rename_pkg::data_t     model_regs [rename_pkg::ARCH_REGS];
  rename_pkg::arch_idx_t exp_reg [256];
  rename_pkg::data_t     exp_data [256];
  int expected_n = 0;
  int commits_seen = 0;
  int sent = 0;
  int credit_returns = 0;
  int owed = 0;      // Credits the consumer still has to hand back
  int pending;
  int errors = 0;
  int errors_at_start;
  int tests_run = 0;
  int tests_failed = 0;
  logic  hold_credits = 1'b0;
  string test_name = "";

  rename_pipeline dut (.*);

  always #5 clock = ~clock;

  always @(posedge clock) begin
    if (reset) begin
      credit_returns <= 0;
    end else if (in_credit) begin
      credit_returns <= credit_returns + 1;
    end
  end

  //////////////////////////////
  // Consumer and commit check
  //////////////////////////////
  always @(posedge clock) begin
    if (!reset) begin
      if (commit_valid) begin
        assert (commits_seen < expected_n) else begin
          $display("Unexpected commit in %s with nothing outstanding", test_name);
          errors++;
        end
        assert (commit_reg == exp_reg[commits_seen] &&
                commit_data == exp_data[commits_seen]) else begin
          $display("FAILED %s: expected r%0d = %h, actual r%0d = %h", test_name,
                   exp_reg[commits_seen], exp_data[commits_seen], commit_reg, commit_data);
          errors++;
        end
        commits_seen <= commits_seen + 1;
      end
      pending = owed + int'(commit_valid);
      commit_credit <= !hold_credits && pending > 0;
      owed <= (!hold_credits && pending > 0) ? pending - 1 : pending;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      bits = {bits[14:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic logic [15:0] alu_inst(input rename_pkg::opcode_e op,
                                           input int rd, input int rs1, input int rs2);
    return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
  endfunction

  function automatic logic [15:0] ldi_inst(input int rd, input logic [8:0] imm);
    return {rename_pkg::OP_LDI, 3'(rd), imm};
  endfunction

  function automatic logic [15:0] random_inst();
    logic [15:0] inst;
    inst = '0;
    inst[15:12] = 4'(rand_bits(3) % 5);  // Legal codes only
    if (inst[15:12] == rename_pkg::OP_LDI) begin
      inst[11:0] = 12'(rand_bits(12));
    end else begin
      inst[11:3] = 9'(rand_bits(9));
    end
    return inst;
  endfunction

  function automatic int total_errors();
    return errors + dut.asserts_0.fail_count;
  endfunction

  // Architectural model stepped by one instruction in program order
  task automatic predict(input logic [15:0] inst);
    rename_pkg::data_t a;
    rename_pkg::data_t b;
    rename_pkg::data_t value;
    a = model_regs[inst[8:6]];
    b = model_regs[inst[5:3]];
    case (inst[15:12])
      rename_pkg::OP_ADD: value = a + b;
      rename_pkg::OP_SUB: value = a - b;
      rename_pkg::OP_AND: value = a & b;
      rename_pkg::OP_XOR: value = a ^ b;
      rename_pkg::OP_LDI: value = {7'b0, inst[8:0]};
      default:            return;  // Dropped at decode without a commit
    endcase
    exp_reg[expected_n]    = inst[11:9];
    exp_data[expected_n]   = value;
    model_regs[inst[11:9]] = value;
    expected_n++;
  endtask

  task automatic drive_inst(input logic [15:0] inst);
    in_valid <= 1'b1;
    in_inst  <= inst;
    sent++;
    predict(inst);
  endtask

  task automatic send_inst(input logic [15:0] inst);
    int waited;
    waited = 0;
    @(posedge clock);
    while (sent - credit_returns >= rename_pkg::IN_DEPTH && waited < WAIT_LIMIT) begin
      in_valid <= 1'b0;
      waited++;
      @(posedge clock);
    end
    if (waited < WAIT_LIMIT) begin
      drive_inst(inst);
    end else begin
      $display("Timed out in %s waiting for an input credit", test_name);
      errors++;
    end
  endtask

  // Waits for every commit and for all input and output credits
  task automatic wait_drained();
    int waited;
    waited = 0;
    @(posedge clock);
    in_valid <= 1'b0;
    while ((commits_seen < expected_n || credit_returns < sent || owed != 0)
           && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clock);
    end
    assert (waited < WAIT_LIMIT) else begin
      $display("Timed out in %s: %0d of %0d commits, %0d of %0d input credits back",
               test_name, commits_seen, expected_n, credit_returns, sent);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = total_errors();
  endtask

  task automatic end_test();
    tests_run++;
    if (total_errors() != errors_at_start) begin
      tests_failed++;
    end
    $display("Test %s finished with %0d errors", test_name, total_errors() - errors_at_start);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int mark;
    int base;
    int to_send;
    reset         = 1'b1;
    in_valid      = 1'b0;
    in_inst       = '0;
    commit_credit = 1'b0;
    for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
      model_regs[r] = '0;
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);

    begin_test("reset_state");
    assert (!commit_valid && !in_credit && !illegal) else begin
      $display("Outputs not low after reset");
      errors++;
    end
    for (int i = 0; i < rename_pkg::IN_DEPTH; i++) begin
      send_inst(ldi_inst(i, 9'(rand_bits(9))));
    end
    wait_drained();
    end_test();

    begin_test("basic_ops");
    for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
      send_inst(ldi_inst(r, 9'(rand_bits(9))));
    end
    send_inst(alu_inst(rename_pkg::OP_ADD, 1, 0, 7));  // Each uses the one before
    send_inst(alu_inst(rename_pkg::OP_SUB, 2, 1, 3));
    send_inst(alu_inst(rename_pkg::OP_AND, 3, 2, 1));
    send_inst(alu_inst(rename_pkg::OP_XOR, 4, 3, 2));
    wait_drained();
    end_test();

    begin_test("free_list_reuse");
    for (int i = 0; i < 40; i++) begin
      send_inst(random_inst());
    end
    wait_drained();
    end_test();

    begin_test("back_pressure");
    hold_credits <= 1'b1;
    base    = commits_seen;
    to_send = 14;
    mark    = 0;
    for (int c = 0; c < 40; c++) begin
      @(posedge clock);
      if (c == 30) begin
        mark = credit_returns;
      end
      if (to_send > 0 && sent - credit_returns < rename_pkg::IN_DEPTH) begin
        drive_inst(random_inst());
        to_send--;
      end else begin
        in_valid <= 1'b0;
      end
    end
    assert (commits_seen - base == rename_pkg::OUT_CREDITS) else begin
      $display("FAILED %s: expected %0d commits while held, actual %0d", test_name,
               rename_pkg::OUT_CREDITS, commits_seen - base);
      errors++;
    end
    assert (credit_returns == mark) else begin
      $display("Input credits kept returning in %s with the pipeline full", test_name);
      errors++;
    end
    assert (to_send > 0) else begin
      $display("Source in %s never ran out of input credits", test_name);
      errors++;
    end
    hold_credits <= 1'b0;
    while (to_send > 0) begin
      send_inst(random_inst());
      to_send--;
    end
    wait_drained();
    end_test();

    begin_test("illegal_opcode");
    assert (!illegal) else begin
      $display("Illegal flag set before any illegal opcode");
      errors++;
    end
    send_inst(ldi_inst(5, 9'h1a5));
    send_inst(alu_inst(rename_pkg::OP_ADD, 6, 5, 5));
    send_inst(16'hf123);  // Unused opcode
    send_inst(alu_inst(rename_pkg::OP_XOR, 7, 6, 5));
    send_inst(alu_inst(rename_pkg::OP_SUB, 0, 7, 6));
    wait_drained();
    assert (illegal) else begin
      $display("FAILED %s: expected illegal = 1, actual %b", test_name, illegal);
      errors++;
    end
    end_test();

    $display("Tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, dut.asserts_0.fail_count);
    if (total_errors() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* all.f */
verilog/rename_pkg.sv
verilog/decode_stage.sv
verilog/rename_stage.sv
verilog/execute_stage.sv
verilog/commit_stage.sv
verilog/rename_pipeline.sv
sim/rename_pipeline_asserts.sv
sim/rename_pipeline_tb.sv

/* Bender.yml */
package:
  name: rename_pipeline

sources:
  - verilog/rename_pkg.sv
  - verilog/decode_stage.sv
  - verilog/rename_stage.sv
  - verilog/execute_stage.sv
  - verilog/commit_stage.sv
  - verilog/rename_pipeline.sv
  - target: test
    files:
      - sim/rename_pipeline_asserts.sv
      - sim/rename_pipeline_tb.sv
